/* cce_defines.svh */
`ifndef CCE_DEFINES_SVH
`define CCE_DEFINES_SVH

// operand and GPR file
`define CCE_GPR_WIDTH 64
`define CCE_NUM_GPR 8
`define CCE_GPR_SEL_WIDTH 3

// physical address
`define CCE_PADDR_WIDTH 40

// LCE ids and way ids
`define CCE_LCE_ID_WIDTH 4
`define CCE_NUM_LCE 8
`define CCE_ASSOC_WIDTH 3

// MSHR flag count
`define CCE_NUM_FLAGS 13

`endif

/* cce_pkg.sv */
`include "cce_defines.svh"

package cce_pkg;

  // MOESIF plus invalid, I must stay at zero
  typedef enum logic [2:0] {
    e_COH_I = 3'b000,
    e_COH_S = 3'b001,
    e_COH_E = 3'b010,
    e_COH_F = 3'b011,
    e_COH_M = 3'b110,
    e_COH_O = 3'b111
  } coh_state_e;

  typedef enum logic [2:0] {
    e_src_sel_gpr     = 3'd0,
    e_src_sel_flag    = 3'd1,
    e_src_sel_special = 3'd2,
    e_src_sel_queue   = 3'd3,
    e_src_sel_imm     = 3'd4,
    e_src_sel_zero    = 3'd5
  } src_sel_e;

  // bit positions in mshr_s.flags
  typedef enum logic [3:0] {
    e_opd_rqf, e_opd_ucf, e_opd_nerf, e_opd_nwbf, e_opd_pf,
    e_opd_sf, e_opd_csf, e_opd_cef, e_opd_cmf, e_opd_cof,
    e_opd_cff, e_opd_rf, e_opd_uf
  } flag_e;

  typedef enum logic [3:0] {
    e_opd_req_lce, e_opd_req_addr, e_opd_req_way,
    e_opd_lru_addr, e_opd_lru_way,
    e_opd_owner_lce, e_opd_owner_way,
    e_opd_next_coh_state, e_opd_lru_coh_state, e_opd_owner_coh_state,
    e_opd_flags,
    e_opd_sharers_hit, e_opd_sharers_way, e_opd_sharers_state
  } special_e;

  typedef enum logic [1:0] {
    e_opd_mem_resp_v = 2'd0,
    e_opd_lce_resp_v = 2'd1,
    e_opd_lce_req_v  = 2'd2
  } queue_e;

  // queue selector padded out to the union width
  typedef struct packed {
    logic [1:0] pad;
    queue_e     sel;
  } queue_src_s;

  typedef union packed {
    logic [3:0] gpr;
    flag_e      flag;
    special_e   special;
    queue_src_s q;
  } src_u;

  typedef enum logic [3:0] {
    e_mux_sel_addr_r0, e_mux_sel_addr_r1, e_mux_sel_addr_r2, e_mux_sel_addr_r3,
    e_mux_sel_addr_r4, e_mux_sel_addr_r5, e_mux_sel_addr_r6, e_mux_sel_addr_r7,
    e_mux_sel_addr_mshr_req, e_mux_sel_addr_mshr_lru, e_mux_sel_addr_0
  } addr_sel_e;

  typedef enum logic [3:0] {
    e_mux_sel_lce_r0, e_mux_sel_lce_r1, e_mux_sel_lce_r2, e_mux_sel_lce_r3,
    e_mux_sel_lce_r4, e_mux_sel_lce_r5, e_mux_sel_lce_r6, e_mux_sel_lce_r7,
    e_mux_sel_lce_mshr_req, e_mux_sel_lce_mshr_owner, e_mux_sel_lce_0
  } lce_sel_e;

  typedef enum logic [3:0] {
    e_mux_sel_way_r0, e_mux_sel_way_r1, e_mux_sel_way_r2, e_mux_sel_way_r3,
    e_mux_sel_way_r4, e_mux_sel_way_r5, e_mux_sel_way_r6, e_mux_sel_way_r7,
    e_mux_sel_way_mshr_req, e_mux_sel_way_mshr_owner, e_mux_sel_way_mshr_lru,
    e_mux_sel_way_sh_way, e_mux_sel_way_0
  } way_sel_e;

  typedef enum logic [3:0] {
    e_mux_sel_coh_r0, e_mux_sel_coh_r1, e_mux_sel_coh_r2, e_mux_sel_coh_r3,
    e_mux_sel_coh_r4, e_mux_sel_coh_r5, e_mux_sel_coh_r6, e_mux_sel_coh_r7,
    e_mux_sel_coh_next, e_mux_sel_coh_lru, e_mux_sel_coh_owner,
    e_mux_sel_coh_sharer, e_mux_sel_coh_imm
  } coh_sel_e;

  typedef struct packed {
    logic [`CCE_LCE_ID_WIDTH-1:0] lce_id;
    logic [`CCE_PADDR_WIDTH-1:0]  paddr;
    logic [`CCE_ASSOC_WIDTH-1:0]  way_id;
    logic [`CCE_PADDR_WIDTH-1:0]  lru_paddr;
    logic [`CCE_ASSOC_WIDTH-1:0]  lru_way_id;
    logic [`CCE_LCE_ID_WIDTH-1:0] owner_lce_id;
    logic [`CCE_ASSOC_WIDTH-1:0]  owner_way_id;
    coh_state_e                   next_coh_state;
    coh_state_e                   lru_coh_state;
    coh_state_e                   owner_coh_state;
    logic [`CCE_NUM_FLAGS-1:0]    flags;
  } mshr_s;

endpackage

/* cce_src_if.sv */
`timescale 1ns/1ps
`include "cce_defines.svh"

interface cce_src_if;
  import cce_pkg::*;

  logic [`CCE_NUM_GPR-1:0][`CCE_GPR_WIDTH-1:0] gpr;
  logic [`CCE_GPR_WIDTH-1:0]                   imm;
  mshr_s                                       mshr;
  // per-LCE directory lookup results
  logic [`CCE_NUM_LCE-1:0]                     sharer_hits;
  logic [`CCE_NUM_LCE-1:0][`CCE_ASSOC_WIDTH-1:0] sharer_ways;
  coh_state_e [`CCE_NUM_LCE-1:0]               sharer_states;

  // select side only reads
  modport sel (
    input gpr,
    input imm,
    input mshr,
    input sharer_hits,
    input sharer_ways,
    input sharer_states
  );

  // driving side at the top level
  modport src (
    output gpr,
    output imm,
    output mshr,
    output sharer_hits,
    output sharer_ways,
    output sharer_states
  );

endinterface

/* cce_sharer_lookup.sv */
`timescale 1ns/1ps
`include "cce_defines.svh"

module cce_sharer_lookup #(
  parameter type entry_t = logic
) (
  input  logic [`CCE_GPR_SEL_WIDTH-1:0]                gpr_sel_i,
  input  logic [`CCE_NUM_GPR-1:0][`CCE_GPR_WIDTH-1:0] gpr_i,
  input  entry_t [`CCE_NUM_LCE-1:0]                   entries_i,
  output entry_t                                      entry_o
);

  localparam int lg_num_lce_lp = $clog2(`CCE_NUM_LCE);

  logic [`CCE_GPR_WIDTH-1:0] lce_index;

  // the named GPR holds an LCE id
  assign lce_index = gpr_i[gpr_sel_i];

  // ids past the last LCE read as an empty entry
  assign entry_o = (lce_index < `CCE_NUM_LCE)
                   ? entries_i[lce_index[lg_num_lce_lp-1:0]]
                   : entry_t'('0);

endmodule

/* cce_operand_sel.sv */
`timescale 1ns/1ps
`include "cce_defines.svh"

module cce_operand_sel #(
  parameter bit sharer_src_en_p = 1'b1
) (
  input  logic                            clk_i,
  input  logic                            arst_n_i,
  input  logic                            inst_v_i,
  input  cce_pkg::src_sel_e               sel_i,
  input  cce_pkg::src_u                   src_i,
  input  logic                            sharer_hit_i,
  input  logic [`CCE_ASSOC_WIDTH-1:0]     sharer_way_i,
  input  cce_pkg::coh_state_e             sharer_state_i,
  input  logic                            mem_resp_v_i,
  input  logic                            lce_resp_v_i,
  input  logic                            lce_req_v_i,
  cce_src_if.sel                          src_if,
  output logic [`CCE_GPR_WIDTH-1:0]       operand_o
);

  import cce_pkg::*;

  localparam int coh_width_lp = $bits(coh_state_e);

  logic [`CCE_GPR_WIDTH-1:0] operand_n;

  always_comb begin
    operand_n = '0;
    case (sel_i)
      e_src_sel_gpr: begin
        if (src_i.gpr < `CCE_NUM_GPR) begin
          operand_n = src_if.gpr[src_i.gpr[`CCE_GPR_SEL_WIDTH-1:0]];
        end
      end
      e_src_sel_flag: begin
        // codes past the last flag give zero
        if (src_i.flag < `CCE_NUM_FLAGS) begin
          operand_n[0] = src_if.mshr.flags[src_i.flag];
        end
      end
      e_src_sel_special: begin
        case (src_i.special)
          e_opd_req_lce:
            operand_n[`CCE_LCE_ID_WIDTH-1:0] = src_if.mshr.lce_id;
          e_opd_req_addr:
            operand_n[`CCE_PADDR_WIDTH-1:0] = src_if.mshr.paddr;
          e_opd_req_way:
            operand_n[`CCE_ASSOC_WIDTH-1:0] = src_if.mshr.way_id;
          e_opd_lru_addr:
            operand_n[`CCE_PADDR_WIDTH-1:0] = src_if.mshr.lru_paddr;
          e_opd_lru_way:
            operand_n[`CCE_ASSOC_WIDTH-1:0] = src_if.mshr.lru_way_id;
          e_opd_owner_lce:
            operand_n[`CCE_LCE_ID_WIDTH-1:0] = src_if.mshr.owner_lce_id;
          e_opd_owner_way:
            operand_n[`CCE_ASSOC_WIDTH-1:0] = src_if.mshr.owner_way_id;
          e_opd_next_coh_state:
            operand_n[coh_width_lp-1:0] = src_if.mshr.next_coh_state;
          e_opd_lru_coh_state:
            operand_n[coh_width_lp-1:0] = src_if.mshr.lru_coh_state;
          e_opd_owner_coh_state:
            operand_n[coh_width_lp-1:0] = src_if.mshr.owner_coh_state;
          // imm acts as a flag mask
          e_opd_flags:
            operand_n[`CCE_NUM_FLAGS-1:0] = src_if.mshr.flags & src_if.imm[`CCE_NUM_FLAGS-1:0];
          // sharer reads only on the operand that owns the lookups
          e_opd_sharers_hit:
            if (sharer_src_en_p) operand_n[0] = sharer_hit_i;
          e_opd_sharers_way:
            if (sharer_src_en_p) operand_n[`CCE_ASSOC_WIDTH-1:0] = sharer_way_i;
          e_opd_sharers_state:
            if (sharer_src_en_p) operand_n[coh_width_lp-1:0] = sharer_state_i;
          default: operand_n = '0;
        endcase
      end
      e_src_sel_queue: begin
        case (src_i.q.sel)
          e_opd_mem_resp_v: operand_n[0] = mem_resp_v_i;
          e_opd_lce_resp_v: operand_n[0] = lce_resp_v_i;
          e_opd_lce_req_v:  operand_n[0] = lce_req_v_i;
          default:          operand_n = '0;
        endcase
      end
      e_src_sel_imm: operand_n = src_if.imm;
      default:       operand_n = '0;
    endcase
  end

  // capture on the instruction strobe, hold otherwise
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      operand_o <= '0;
    end else if (inst_v_i) begin
      operand_o <= operand_n;
    end
  end

endmodule

/* cce_fu_sel.sv */
`timescale 1ns/1ps
`include "cce_defines.svh"

module cce_fu_sel (
  input  logic                            clk_i,
  input  logic                            arst_n_i,
  input  logic                            inst_v_i,
  input  cce_pkg::addr_sel_e              addr_sel_i,
  input  cce_pkg::lce_sel_e               lce_sel_i,
  input  cce_pkg::way_sel_e               way_sel_i,
  input  cce_pkg::coh_sel_e               coh_sel_i,
  input  logic [`CCE_ASSOC_WIDTH-1:0]     sharer_way_i,
  input  cce_pkg::coh_state_e             sharer_state_i,
  cce_src_if.sel                          src_if,
  output logic [`CCE_PADDR_WIDTH-1:0]     addr_o,
  output logic                            addr_bypass_o,
  output logic [`CCE_LCE_ID_WIDTH-1:0]    lce_o,
  output logic [`CCE_ASSOC_WIDTH-1:0]     way_o,
  output cce_pkg::coh_state_e             state_o,
  output logic                            result_v_o
);

  import cce_pkg::*;

  localparam int coh_width_lp = $bits(coh_state_e);

  logic [`CCE_PADDR_WIDTH-1:0]  addr_n;
  logic                         addr_bypass_n;
  logic [`CCE_LCE_ID_WIDTH-1:0] lce_n;
  logic [`CCE_ASSOC_WIDTH-1:0]  way_n;
  coh_state_e                   state_n;

  // r0-r7 occupy codes 0-7 in every mux, low bits pick the GPR
  always_comb begin
    addr_n        = '0;
    addr_bypass_n = 1'b0;
    if (addr_sel_i <= e_mux_sel_addr_r7) begin
      addr_n        = src_if.gpr[addr_sel_i[`CCE_GPR_SEL_WIDTH-1:0]][`CCE_PADDR_WIDTH-1:0];
      addr_bypass_n = 1'b1;
    end else if (addr_sel_i == e_mux_sel_addr_mshr_req) begin
      addr_n = src_if.mshr.paddr;
    end else if (addr_sel_i == e_mux_sel_addr_mshr_lru) begin
      addr_n = src_if.mshr.lru_paddr;
    end else if (addr_sel_i == e_mux_sel_addr_0) begin
      addr_bypass_n = 1'b1;
    end
  end

  always_comb begin
    lce_n = '0;
    if (lce_sel_i <= e_mux_sel_lce_r7) begin
      lce_n = src_if.gpr[lce_sel_i[`CCE_GPR_SEL_WIDTH-1:0]][`CCE_LCE_ID_WIDTH-1:0];
    end else if (lce_sel_i == e_mux_sel_lce_mshr_req) begin
      lce_n = src_if.mshr.lce_id;
    end else if (lce_sel_i == e_mux_sel_lce_mshr_owner) begin
      lce_n = src_if.mshr.owner_lce_id;
    end
  end

  always_comb begin
    way_n = '0;
    case (way_sel_i)
      e_mux_sel_way_mshr_req:   way_n = src_if.mshr.way_id;
      e_mux_sel_way_mshr_owner: way_n = src_if.mshr.owner_way_id;
      e_mux_sel_way_mshr_lru:   way_n = src_if.mshr.lru_way_id;
      e_mux_sel_way_sh_way:     way_n = sharer_way_i;
      default: begin
        if (way_sel_i <= e_mux_sel_way_r7) begin
          way_n = src_if.gpr[way_sel_i[`CCE_GPR_SEL_WIDTH-1:0]][`CCE_ASSOC_WIDTH-1:0];
        end
      end
    endcase
  end

  // unused coherence codes fall back to invalid
  always_comb begin
    state_n = e_COH_I;
    case (coh_sel_i)
      e_mux_sel_coh_next:   state_n = src_if.mshr.next_coh_state;
      e_mux_sel_coh_lru:    state_n = src_if.mshr.lru_coh_state;
      e_mux_sel_coh_owner:  state_n = src_if.mshr.owner_coh_state;
      e_mux_sel_coh_sharer: state_n = sharer_state_i;
      e_mux_sel_coh_imm:    state_n = coh_state_e'(src_if.imm[coh_width_lp-1:0]);
      default: begin
        if (coh_sel_i <= e_mux_sel_coh_r7) begin
          state_n = coh_state_e'(
            src_if.gpr[coh_sel_i[`CCE_GPR_SEL_WIDTH-1:0]][coh_width_lp-1:0]);
        end
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      addr_o        <= '0;
      addr_bypass_o <= 1'b0;
      lce_o         <= '0;
      way_o         <= '0;
      state_o       <= e_COH_I;
      result_v_o    <= 1'b0;
    end else begin
      result_v_o <= inst_v_i;
      if (inst_v_i) begin
        addr_o        <= addr_n;
        addr_bypass_o <= addr_bypass_n;
        lce_o         <= lce_n;
        way_o         <= way_n;
        state_o       <= state_n;
      end
    end
  end

endmodule

/* cce_src_sel_top.sv */
`timescale 1ns/1ps
`include "cce_defines.svh"

module cce_src_sel_top (
  input  logic                                        clk_i,
  input  logic                                        arst_n_i,
  input  logic                                        inst_v_i,
  input  cce_pkg::src_sel_e                           src_a_sel_i,
  input  cce_pkg::src_u                               src_a_i,
  input  cce_pkg::src_sel_e                           src_b_sel_i,
  input  cce_pkg::src_u                               src_b_i,
  input  cce_pkg::addr_sel_e                          addr_sel_i,
  input  cce_pkg::lce_sel_e                           lce_sel_i,
  input  cce_pkg::way_sel_e                           way_sel_i,
  input  cce_pkg::coh_sel_e                           coh_sel_i,
  input  logic [`CCE_NUM_GPR-1:0][`CCE_GPR_WIDTH-1:0] gpr_i,
  input  logic [`CCE_GPR_WIDTH-1:0]                   imm_i,
  input  cce_pkg::mshr_s                              mshr_i,
  input  logic [`CCE_NUM_LCE-1:0]                     sharer_hits_i,
  input  logic [`CCE_NUM_LCE-1:0][`CCE_ASSOC_WIDTH-1:0] sharer_ways_i,
  input  cce_pkg::coh_state_e [`CCE_NUM_LCE-1:0]      sharer_states_i,
  input  logic                                        mem_resp_v_i,
  input  logic                                        lce_resp_v_i,
  input  logic                                        lce_req_v_i,
  output logic [`CCE_GPR_WIDTH-1:0]                   src_a_o,
  output logic [`CCE_GPR_WIDTH-1:0]                   src_b_o,
  output logic [`CCE_PADDR_WIDTH-1:0]                 addr_o,
  output logic                                        addr_bypass_o,
  output logic [`CCE_LCE_ID_WIDTH-1:0]                lce_o,
  output logic [`CCE_ASSOC_WIDTH-1:0]                 way_o,
  output cce_pkg::coh_state_e                         state_o,
  output logic                                        result_v_o
);

  import cce_pkg::*;

  logic                          a_sharer_hit;
  logic [`CCE_ASSOC_WIDTH-1:0]   a_sharer_way;
  coh_state_e                    a_sharer_state;
  logic [`CCE_ASSOC_WIDTH-1:0]   fu_sharer_way;
  coh_state_e                    fu_sharer_state;

  cce_src_if src_if ();

  assign src_if.gpr           = gpr_i;
  assign src_if.imm           = imm_i;
  assign src_if.mshr          = mshr_i;
  assign src_if.sharer_hits   = sharer_hits_i;
  assign src_if.sharer_ways   = sharer_ways_i;
  assign src_if.sharer_states = sharer_states_i;

  // operand A sharer specials, LCE id taken from the GPR named by src_b
  cce_sharer_lookup #(.entry_t(logic)) a_hit_lookup (
    .gpr_sel_i(src_b_i.gpr[`CCE_GPR_SEL_WIDTH-1:0]), .gpr_i(src_if.gpr),
    .entries_i(src_if.sharer_hits), .entry_o(a_sharer_hit));

  cce_sharer_lookup #(.entry_t(logic [`CCE_ASSOC_WIDTH-1:0])) a_way_lookup (
    .gpr_sel_i(src_b_i.gpr[`CCE_GPR_SEL_WIDTH-1:0]), .gpr_i(src_if.gpr),
    .entries_i(src_if.sharer_ways), .entry_o(a_sharer_way));

  cce_sharer_lookup #(.entry_t(coh_state_e)) a_state_lookup (
    .gpr_sel_i(src_b_i.gpr[`CCE_GPR_SEL_WIDTH-1:0]), .gpr_i(src_if.gpr),
    .entries_i(src_if.sharer_states), .entry_o(a_sharer_state));

  // unit-select sharer sources follow src_a
  cce_sharer_lookup #(.entry_t(logic [`CCE_ASSOC_WIDTH-1:0])) fu_way_lookup (
    .gpr_sel_i(src_a_i.gpr[`CCE_GPR_SEL_WIDTH-1:0]), .gpr_i(src_if.gpr),
    .entries_i(src_if.sharer_ways), .entry_o(fu_sharer_way));

  cce_sharer_lookup #(.entry_t(coh_state_e)) fu_state_lookup (
    .gpr_sel_i(src_a_i.gpr[`CCE_GPR_SEL_WIDTH-1:0]), .gpr_i(src_if.gpr),
    .entries_i(src_if.sharer_states), .entry_o(fu_sharer_state));

  cce_operand_sel #(.sharer_src_en_p(1'b1)) src_a_sel (
    .clk_i, .arst_n_i, .inst_v_i,
    .sel_i(src_a_sel_i), .src_i(src_a_i),
    .sharer_hit_i(a_sharer_hit), .sharer_way_i(a_sharer_way),
    .sharer_state_i(a_sharer_state),
    .mem_resp_v_i, .lce_resp_v_i, .lce_req_v_i,
    .src_if(src_if.sel), .operand_o(src_a_o));

  // operand B ignores its sharer inputs
  cce_operand_sel #(.sharer_src_en_p(1'b0)) src_b_sel (
    .clk_i, .arst_n_i, .inst_v_i,
    .sel_i(src_b_sel_i), .src_i(src_b_i),
    .sharer_hit_i(a_sharer_hit), .sharer_way_i(a_sharer_way),
    .sharer_state_i(a_sharer_state),
    .mem_resp_v_i, .lce_resp_v_i, .lce_req_v_i,
    .src_if(src_if.sel), .operand_o(src_b_o));

  cce_fu_sel fu_sel (
    .clk_i, .arst_n_i, .inst_v_i,
    .addr_sel_i, .lce_sel_i, .way_sel_i, .coh_sel_i,
    .sharer_way_i(fu_sharer_way), .sharer_state_i(fu_sharer_state),
    .src_if(src_if.sel),
    .addr_o, .addr_bypass_o, .lce_o, .way_o, .state_o, .result_v_o);

endmodule

/* cce_src_properties.sv */
`timescale 1ns/1ps
`include "cce_defines.svh"

module cce_src_properties #(
  // both operands, address, bypass, LCE, way and state
  parameter int width_p = 2 * `CCE_GPR_WIDTH + `CCE_PADDR_WIDTH + 1
                          + `CCE_LCE_ID_WIDTH + `CCE_ASSOC_WIDTH + 3
) (
  input logic               clk_i,
  input logic               arst_n_i,
  input logic               inst_v_i,
  input logic               result_v_i,
  input logic [width_p-1:0] outputs_i
);

  int fail_cnt = 0;

  strobe_to_result: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    result_v_i == $past(inst_v_i))
    else begin
      fail_cnt++;
      $error("result valid does not follow the strobe of the previous cycle");
    end

  hold_without_result: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !result_v_i |-> $stable(outputs_i))
    else begin
      fail_cnt++;
      $error("outputs changed in a cycle without a result");
    end

  known_outputs: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !$isunknown({result_v_i, outputs_i}))
    else begin
      fail_cnt++;
      $error("an output is unknown after reset");
    end

endmodule

bind cce_src_sel_top cce_src_properties properties_i (
  .clk_i(clk_i),
  .arst_n_i(arst_n_i),
  .inst_v_i(inst_v_i),
  .result_v_i(result_v_o),
  .outputs_i({src_a_o, src_b_o, addr_o, addr_bypass_o, lce_o, way_o, state_o})
);

/* cce_src_checker.sv */
`timescale 1ns/1ps
`include "cce_defines.svh"

module cce_src_checker (
  input  logic                                          clk_i,
  input  logic                                          arst_n_i,
  input  logic                                          inst_v_i,
  input  cce_pkg::src_sel_e                             src_a_sel_i,
  input  cce_pkg::src_u                                 src_a_i,
  input  cce_pkg::src_sel_e                             src_b_sel_i,
  input  cce_pkg::src_u                                 src_b_i,
  input  cce_pkg::addr_sel_e                            addr_sel_i,
  input  cce_pkg::lce_sel_e                             lce_sel_i,
  input  cce_pkg::way_sel_e                             way_sel_i,
  input  cce_pkg::coh_sel_e                             coh_sel_i,
  input  logic [`CCE_NUM_GPR-1:0][`CCE_GPR_WIDTH-1:0]   gpr_i,
  input  logic [`CCE_GPR_WIDTH-1:0]                     imm_i,
  input  cce_pkg::mshr_s                                mshr_i,
  input  logic [`CCE_NUM_LCE-1:0]                       sharer_hits_i,
  input  logic [`CCE_NUM_LCE-1:0][`CCE_ASSOC_WIDTH-1:0] sharer_ways_i,
  input  cce_pkg::coh_state_e [`CCE_NUM_LCE-1:0]        sharer_states_i,
  input  logic                                          mem_resp_v_i,
  input  logic                                          lce_resp_v_i,
  input  logic                                          lce_req_v_i,
  input  logic [`CCE_GPR_WIDTH-1:0]                     dut_src_a_i,
  input  logic [`CCE_GPR_WIDTH-1:0]                     dut_src_b_i,
  input  logic [`CCE_PADDR_WIDTH-1:0]                   dut_addr_i,
  input  logic                                          dut_addr_bypass_i,
  input  logic [`CCE_LCE_ID_WIDTH-1:0]                  dut_lce_i,
  input  logic [`CCE_ASSOC_WIDTH-1:0]                   dut_way_i,
  input  cce_pkg::coh_state_e                           dut_state_i,
  input  logic                                          dut_result_v_i,
  output int                                            err_cnt_o,
  output int                                            result_cnt_o
);

  import cce_pkg::*;

  // model of the output registers
  logic [`CCE_GPR_WIDTH-1:0]    exp_src_a;
  logic [`CCE_GPR_WIDTH-1:0]    exp_src_b;
  logic [`CCE_PADDR_WIDTH-1:0]  exp_addr;
  logic                         exp_bypass;
  logic [`CCE_LCE_ID_WIDTH-1:0] exp_lce;
  logic [`CCE_ASSOC_WIDTH-1:0]  exp_way;
  logic [2:0]                   exp_state;
  logic                         exp_v;
  int                           err_cnt = 0;
  int                           result_cnt = 0;

  assign err_cnt_o    = err_cnt;
  assign result_cnt_o = result_cnt;

  // the whole 64-bit GPR value counts toward the LCE range
  function automatic logic [63:0] lce_from_gpr(input logic [3:0] code);
    return gpr_i[code[2:0]];
  endfunction

  function automatic logic [63:0] special_model(input logic [3:0] code, input bit a_side);
    logic [63:0] lce;
    lce = lce_from_gpr(src_b_i.gpr);
    case (code)
      4'd0:  return 64'(mshr_i.lce_id);
      4'd1:  return 64'(mshr_i.paddr);
      4'd2:  return 64'(mshr_i.way_id);
      4'd3:  return 64'(mshr_i.lru_paddr);
      4'd4:  return 64'(mshr_i.lru_way_id);
      4'd5:  return 64'(mshr_i.owner_lce_id);
      4'd6:  return 64'(mshr_i.owner_way_id);
      4'd7:  return 64'(mshr_i.next_coh_state);
      4'd8:  return 64'(mshr_i.lru_coh_state);
      4'd9:  return 64'(mshr_i.owner_coh_state);
      4'd10: return 64'(mshr_i.flags & imm_i[`CCE_NUM_FLAGS-1:0]);
      default: ;
    endcase
    // sharer specials exist on operand A only
    if (!a_side || code > 4'd13 || lce >= `CCE_NUM_LCE) begin
      return '0;
    end
    case (code)
      4'd11:   return 64'(sharer_hits_i[lce[2:0]]);
      4'd12:   return 64'(sharer_ways_i[lce[2:0]]);
      default: return 64'(sharer_states_i[lce[2:0]]);
    endcase
  endfunction

  function automatic logic [63:0] operand_model(input logic [2:0] sel, input logic [3:0] code,
                                                input bit a_side);
    logic [2:0] queues;
    queues = {lce_req_v_i, lce_resp_v_i, mem_resp_v_i};
    if (sel == 3'd0 && code < `CCE_NUM_GPR) return gpr_i[code[2:0]];
    if (sel == 3'd1 && code < `CCE_NUM_FLAGS) return 64'(mshr_i.flags[code]);
    if (sel == 3'd2) return special_model(code, a_side);
    if (sel == 3'd3 && code[1:0] != 2'd3) return 64'(queues[code[1:0]]);
    if (sel == 3'd4) return imm_i;
    return '0;
  endfunction

  // bypass bit on top of the address
  function automatic logic [`CCE_PADDR_WIDTH:0] addr_model();
    if (addr_sel_i < 4'd8) return {1'b1, gpr_i[addr_sel_i[2:0]][`CCE_PADDR_WIDTH-1:0]};
    if (addr_sel_i == 4'd8) return {1'b0, mshr_i.paddr};
    if (addr_sel_i == 4'd9) return {1'b0, mshr_i.lru_paddr};
    return {addr_sel_i == 4'd10, `CCE_PADDR_WIDTH'(0)};
  endfunction

  function automatic logic [`CCE_LCE_ID_WIDTH-1:0] lce_model();
    if (lce_sel_i < 4'd8) return gpr_i[lce_sel_i[2:0]][`CCE_LCE_ID_WIDTH-1:0];
    if (lce_sel_i == 4'd8) return mshr_i.lce_id;
    if (lce_sel_i == 4'd9) return mshr_i.owner_lce_id;
    return '0;
  endfunction

  function automatic logic [`CCE_ASSOC_WIDTH-1:0] way_model();
    logic [63:0] lce;
    lce = lce_from_gpr(src_a_i.gpr);
    if (way_sel_i < 4'd8) return gpr_i[way_sel_i[2:0]][`CCE_ASSOC_WIDTH-1:0];
    if (way_sel_i == 4'd8) return mshr_i.way_id;
    if (way_sel_i == 4'd9) return mshr_i.owner_way_id;
    if (way_sel_i == 4'd10) return mshr_i.lru_way_id;
    if (way_sel_i == 4'd11 && lce < `CCE_NUM_LCE) return sharer_ways_i[lce[2:0]];
    return '0;
  endfunction

  // unused codes read as I, which is zero
  function automatic logic [2:0] state_model();
    logic [63:0] lce;
    lce = lce_from_gpr(src_a_i.gpr);
    if (coh_sel_i < 4'd8) return gpr_i[coh_sel_i[2:0]][2:0];
    if (coh_sel_i == 4'd8) return mshr_i.next_coh_state;
    if (coh_sel_i == 4'd9) return mshr_i.lru_coh_state;
    if (coh_sel_i == 4'd10) return mshr_i.owner_coh_state;
    if (coh_sel_i == 4'd11 && lce < `CCE_NUM_LCE) return sharer_states_i[lce[2:0]];
    if (coh_sel_i == 4'd12) return imm_i[2:0];
    return 3'd0;
  endfunction

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (act !== exp) begin
      err_cnt++;
      $display("ERR t=%0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  always @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      exp_src_a  = '0;
      exp_src_b  = '0;
      exp_addr   = '0;
      exp_bypass = 1'b0;
      exp_lce    = '0;
      exp_way    = '0;
      exp_state  = 3'd0;
      exp_v      = 1'b0;
    end else begin
      // outputs still hold the values from the previous edge
      check("result_v_o", 64'(exp_v), 64'(dut_result_v_i));
      check("src_a_o", exp_src_a, dut_src_a_i);
      check("src_b_o", exp_src_b, dut_src_b_i);
      check("addr_o", 64'(exp_addr), 64'(dut_addr_i));
      check("addr_bypass_o", 64'(exp_bypass), 64'(dut_addr_bypass_i));
      check("lce_o", 64'(exp_lce), 64'(dut_lce_i));
      check("way_o", 64'(exp_way), 64'(dut_way_i));
      check("state_o", 64'(exp_state), 64'(dut_state_i));
      if (dut_result_v_i) begin
        result_cnt++;
      end
      exp_v = inst_v_i;
      if (inst_v_i) begin
        exp_src_a = operand_model(src_a_sel_i, src_a_i, 1'b1);
        exp_src_b = operand_model(src_b_sel_i, src_b_i, 1'b0);
        {exp_bypass, exp_addr} = addr_model();
        exp_lce   = lce_model();
        exp_way   = way_model();
        exp_state = state_model();
      end
    end
  end

endmodule

/* tb_cce_src_sel.sv */
`timescale 1ns/1ps
`include "cce_defines.svh"

module tb_cce_src_sel;

  import cce_pkg::*;

  localparam int num_cycles_lp   = 2000;
  localparam int reset_cycles_lp = 3;
  // stimulus plus reset and drain, with margin
  localparam int timeout_lp      = num_cycles_lp + 100;

  logic                                        clk = 1'b0;
  logic                                        arst_n;
  logic                                        inst_v;
  src_sel_e                                    src_a_sel;
  src_u                                        src_a;
  src_sel_e                                    src_b_sel;
  src_u                                        src_b;
  addr_sel_e                                   addr_sel;
  lce_sel_e                                    lce_sel;
  way_sel_e                                    way_sel;
  coh_sel_e                                    coh_sel;
  logic [`CCE_NUM_GPR-1:0][`CCE_GPR_WIDTH-1:0] gpr;
  logic [`CCE_GPR_WIDTH-1:0]                   imm;
  mshr_s                                       mshr;
  logic [`CCE_NUM_LCE-1:0]                     sharer_hits;
  logic [`CCE_NUM_LCE-1:0][`CCE_ASSOC_WIDTH-1:0] sharer_ways;
  coh_state_e [`CCE_NUM_LCE-1:0]               sharer_states;
  logic                                        mem_resp_v;
  logic                                        lce_resp_v;
  logic                                        lce_req_v;

  logic [`CCE_GPR_WIDTH-1:0]    src_a_out;
  logic [`CCE_GPR_WIDTH-1:0]    src_b_out;
  logic [`CCE_PADDR_WIDTH-1:0]  addr_out;
  logic                         addr_bypass_out;
  logic [`CCE_LCE_ID_WIDTH-1:0] lce_out;
  logic [`CCE_ASSOC_WIDTH-1:0]  way_out;
  coh_state_e                   state_out;
  logic                         result_v_out;

  int          err_cnt;
  int          result_cnt;
  int          cycle_cnt = 0;
  logic [31:0] lcg_state = 32'hdbf8;

  always #20 clk = ~clk;

  cce_src_sel_top cce_src_sel_top_i (
    .clk_i(clk), .arst_n_i(arst_n), .inst_v_i(inst_v),
    .src_a_sel_i(src_a_sel), .src_a_i(src_a), .src_b_sel_i(src_b_sel), .src_b_i(src_b),
    .addr_sel_i(addr_sel), .lce_sel_i(lce_sel), .way_sel_i(way_sel), .coh_sel_i(coh_sel),
    .gpr_i(gpr), .imm_i(imm), .mshr_i(mshr),
    .sharer_hits_i(sharer_hits), .sharer_ways_i(sharer_ways),
    .sharer_states_i(sharer_states),
    .mem_resp_v_i(mem_resp_v), .lce_resp_v_i(lce_resp_v), .lce_req_v_i(lce_req_v),
    .src_a_o(src_a_out), .src_b_o(src_b_out), .addr_o(addr_out),
    .addr_bypass_o(addr_bypass_out), .lce_o(lce_out), .way_o(way_out),
    .state_o(state_out), .result_v_o(result_v_out));

  cce_src_checker src_checker (
    .clk_i(clk), .arst_n_i(arst_n), .inst_v_i(inst_v),
    .src_a_sel_i(src_a_sel), .src_a_i(src_a), .src_b_sel_i(src_b_sel), .src_b_i(src_b),
    .addr_sel_i(addr_sel), .lce_sel_i(lce_sel), .way_sel_i(way_sel), .coh_sel_i(coh_sel),
    .gpr_i(gpr), .imm_i(imm), .mshr_i(mshr),
    .sharer_hits_i(sharer_hits), .sharer_ways_i(sharer_ways),
    .sharer_states_i(sharer_states),
    .mem_resp_v_i(mem_resp_v), .lce_resp_v_i(lce_resp_v), .lce_req_v_i(lce_req_v),
    .dut_src_a_i(src_a_out), .dut_src_b_i(src_b_out), .dut_addr_i(addr_out),
    .dut_addr_bypass_i(addr_bypass_out), .dut_lce_i(lce_out), .dut_way_i(way_out),
    .dut_state_i(state_out), .dut_result_v_i(result_v_out),
    .err_cnt_o(err_cnt), .result_cnt_o(result_cnt));

  // LCG, upper half of the state is the better half
  function automatic logic [15:0] rand16();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[31:16];
  endfunction

  // mode 0-1 in range, mode 2 just past the last LCE, mode 3 left random
  task automatic set_lce_index(input logic [2:0] g, input logic [1:0] mode,
                               input logic [3:0] v);
    if (mode[1] == 1'b0) begin
      gpr[g] = 64'(v[2:0]);
    end else if (mode == 2'd2) begin
      gpr[g] = 64'(v | 4'h8);
    end
  endtask

  task automatic init_inputs();
    arst_n        = 1'b0;
    inst_v        = 1'b0;
    src_a_sel     = e_src_sel_zero;
    src_a         = '0;
    src_b_sel     = e_src_sel_zero;
    src_b         = '0;
    addr_sel      = e_mux_sel_addr_0;
    lce_sel       = e_mux_sel_lce_0;
    way_sel       = e_mux_sel_way_0;
    coh_sel       = e_mux_sel_coh_r0;
    gpr           = '0;
    imm           = '0;
    mshr          = '0;
    sharer_hits   = '0;
    sharer_ways   = '0;
    sharer_states = '0;
    mem_resp_v    = 1'b0;
    lce_resp_v    = 1'b0;
    lce_req_v     = 1'b0;
  endtask

  task automatic drive_random();
    logic [127:0] wide;
    logic [15:0]  r;
    for (int k = 0; k < 8; k++) begin
      wide[k*16 +: 16] = rand16();
    end
    mshr = mshr_s'(wide[$bits(mshr_s)-1:0]);
    for (int g = 0; g < `CCE_NUM_GPR; g++) begin
      gpr[g] = {rand16(), rand16(), rand16(), rand16()};
    end
    imm = {rand16(), rand16(), rand16(), rand16()};
    r = rand16();
    sharer_hits = r[7:0];
    for (int l = 0; l < `CCE_NUM_LCE; l++) begin
      r = rand16();
      sharer_ways[l]   = r[2:0];
      sharer_states[l] = coh_state_e'(r[5:3]);
    end
    // strobe in about three cycles of four
    r = rand16();
    inst_v    = (r[1:0] != 2'b00);
    src_a_sel = src_sel_e'(r[4:2]);
    src_b_sel = src_sel_e'(r[7:5]);
    src_a.gpr = r[11:8];
    src_b.gpr = r[15:12];
    r = rand16();
    addr_sel = addr_sel_e'(r[3:0]);
    lce_sel  = lce_sel_e'(r[7:4]);
    way_sel  = way_sel_e'(r[11:8]);
    coh_sel  = coh_sel_e'(r[15:12]);
    r = rand16();
    mem_resp_v = r[0];
    lce_resp_v = r[1];
    lce_req_v  = r[2];
    set_lce_index(src_a.gpr[2:0], r[4:3], r[11:8]);
    set_lce_index(src_b.gpr[2:0], r[6:5], r[15:12]);
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  initial begin
    wait (cycle_cnt >= timeout_lp);
    $display("timeout: run did not finish within %0d cycles", timeout_lp);
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    init_inputs();
    repeat (reset_cycles_lp) @(posedge clk);
    #2;
    arst_n = 1'b1;
    for (int n = 0; n < num_cycles_lp; n++) begin
      drive_random();
      @(posedge clk);
      #2;
    end
    inst_v = 1'b0;
    // last result is compared on the first edge, the hold on the second
    repeat (2) @(posedge clk);
    #1;
    $display("summary: %0d results, %0d mismatches, %0d assertion failures",
             result_cnt, err_cnt, cce_src_sel_top_i.properties_i.fail_cnt);
    if (err_cnt == 0 && result_cnt > 0 && cce_src_sel_top_i.properties_i.fail_cnt == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* project.f */
+incdir+.
cce_pkg.sv
cce_src_if.sv
cce_sharer_lookup.sv
cce_operand_sel.sv
cce_fu_sel.sv
cce_src_sel_top.sv
cce_src_properties.sv
cce_src_checker.sv
tb_cce_src_sel.sv
